/* verilog/regbank_defs.svh */
`ifndef REGBANK_DEFS_SVH
`define REGBANK_DEFS_SVH

// Architectural register number and data widths
`define REG_NUM_W 4
`define DATA_W 32
`define MODE_W 5

// One-hot physical select, slot 31 never used
`define PHYS_REGS 32

// Architectural numbers where banking changes
`define FIQ_FIRST_REG 8
`define BANKED_FIRST_REG 13
`define PC_REG 15

// Physical slot bases
`define FIQ_HI_BASE 13
`define BANKED_BASE 18
`define PC_INDEX 30

`endif

/* verilog/modePkg.sv */
`default_nettype none
`include "regbank_defs.svh"

package modePkg;

  // ====================
  // CPSR mode field
  // ====================
  typedef enum logic [`MODE_W-1:0] {
    MODE_USR = 5'b10000,
    MODE_FIQ = 5'b10001,
    MODE_IRQ = 5'b10010,
    MODE_SVC = 5'b10011,
    MODE_ABT = 5'b10111,
    MODE_UND = 5'b11011,
    MODE_SYS = 5'b11111
  } cpuMode_e;

  // ====================
  // Register banks
  // ====================
  // Order sets the r13/r14 pair position, system shares user
  typedef enum logic [2:0] {
    BANK_USER = 3'd0,
    BANK_FIQ  = 3'd1,
    BANK_IRQ  = 3'd2,
    BANK_SVC  = 3'd3,
    BANK_ABT  = 3'd4,
    BANK_UND  = 3'd5
  } bankSel_e;

endpackage

`default_nettype wire

/* verilog/instrPkg.sv */
`default_nettype none

package instrPkg;

  // ====================
  // Operand layout
  // ====================
  // DP     rn = [19:16], rm = [3:0]
  // PCREL  rn forced to r15, rm = [3:0]
  // STORE  rn = [19:16], second read = [15:12]
  typedef enum logic [1:0] {
    SRC_DP    = 2'b00,
    SRC_PCREL = 2'b01,
    SRC_STORE = 2'b10
  } regSrc_e;

  // ====================
  // Forwarding select
  // ====================
  // M result is newer, so it wins over W
  typedef enum logic [1:0] {
    FWD_REG = 2'b00,
    FWD_W   = 2'b01,
    FWD_M   = 2'b10
  } fwdSel_e;

endpackage

`default_nettype wire

/* verilog/pipeIfs.sv */
`default_nettype none

// Register number compares, already qualified
interface hazardMatchIf;
  // E sources against M and W destinations
  logic match1EM;
  logic match1EW;
  logic match2EM;
  logic match2EW;
  // D sources against E destination
  logic match1DE;
  logic match2DE;
  // Load sitting in E
  logic loadE;

  modport path (output match1EM, match1EW, match2EM, match2EW, match1DE, match2DE, loadE);
  modport hazard (input match1EM, match1EW, match2EM, match2EW, match1DE, match2DE, loadE);
endinterface

// Stall, flush and forwarding back to the pipe
interface pipeCtrlIf import instrPkg::*; ();
  logic    stallD;
  logic    flushE;
  fwdSel_e fwdA;
  fwdSel_e fwdB;

  modport hazard (output stallD, flushE, fwdA, fwdB);
  // Path only needs the pipeline control
  modport path (input stallD, flushE);
endinterface

`default_nettype wire

/* verilog/addressDecode.sv */
`default_nettype none
`include "regbank_defs.svh"

module addressDecode import modePkg::*; (
  input  logic [`REG_NUM_W-1:0] regNum,
  input  cpuMode_e              mode,
  input  logic                  userBank,
  output logic [`PHYS_REGS-1:0] sel
);

  localparam int IdxW = $clog2(`PHYS_REGS);

  bankSel_e        bank;
  int unsigned     num;
  logic [IdxW-1:0] physIdx;

  // Mode to bank, user-bank strobe forces user
  always_comb begin
    if (userBank) begin
      bank = BANK_USER;
    end else begin
      case (mode)
        MODE_FIQ: bank = BANK_FIQ;
        MODE_IRQ: bank = BANK_IRQ;
        MODE_SVC: bank = BANK_SVC;
        MODE_ABT: bank = BANK_ABT;
        MODE_UND: bank = BANK_UND;
        // USR, SYS and anything unknown
        default:  bank = BANK_USER;
      endcase
    end
  end

  // Architectural number to physical slot
  always_comb begin
    num = int'(regNum);
    if (num < `FIQ_FIRST_REG) begin
      // Low registers never banked
      physIdx = IdxW'(num);
    end else if (num < `BANKED_FIRST_REG) begin
      // r8-r12, only FIQ has its own copy
      if (bank == BANK_FIQ) begin
        physIdx = IdxW'(`FIQ_HI_BASE + (num - `FIQ_FIRST_REG));
      end else begin
        physIdx = IdxW'(num);
      end
    end else if (num < `PC_REG) begin
      // r13/r14 pair per bank
      physIdx = IdxW'(`BANKED_BASE + 2 * int'(bank) + (num - `BANKED_FIRST_REG));
    end else begin
      physIdx = IdxW'(`PC_INDEX);
    end
    sel = '0;
    sel[physIdx] = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/addressPath.sv */
`default_nettype none
`include "regbank_defs.svh"

module addressPath import modePkg::*, instrPkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [31:0]           instrD,
  input  logic                  instrValid,
  input  regSrc_e               regSrcD,
  input  logic                  aluSrcD,
  input  logic                  userBankD,
  input  logic                  regWriteD,
  input  logic                  loadD,
  input  cpuMode_e              mode,
  output logic [`PHYS_REGS-1:0] rdSel1,
  output logic [`PHYS_REGS-1:0] rdSel2,
  output logic [`PHYS_REGS-1:0] wrSel,
  output logic                  wrEn,
  hazardMatchIf.path            match,
  pipeCtrlIf.path               ctrl
);

  // Decode stage
  logic [`REG_NUM_W-1:0] rs1D;
  logic [`REG_NUM_W-1:0] rs2D;
  logic [`REG_NUM_W-1:0] rdD;
  logic                  useRs2D;
  logic                  writeD;
  logic                  acceptD;
  logic                  issueD;
  // Execute stage
  logic [`REG_NUM_W-1:0] rs1E;
  logic [`REG_NUM_W-1:0] rs2E;
  logic [`REG_NUM_W-1:0] rdE;
  cpuMode_e              modeE;
  logic                  userBankE;
  logic                  useRs1E;
  logic                  useRs2E;
  logic                  regWriteE;
  logic                  loadE;
  // Memory and writeback stages
  logic [`REG_NUM_W-1:0] rdM;
  logic [`REG_NUM_W-1:0] rdW;
  cpuMode_e              modeM;
  cpuMode_e              modeW;
  logic                  userBankM;
  logic                  userBankW;
  logic                  regWriteM;
  logic                  regWriteW;

  // ====================
  // Decode
  // ====================
  // Source numbers per operand layout
  always_comb begin
    rs1D = instrD[19:16];
    rs2D = instrD[3:0];
    case (regSrcD)
      SRC_PCREL: rs1D = `REG_NUM_W'(`PC_REG);
      SRC_STORE: rs2D = instrD[15:12];
      default:   rs2D = instrD[3:0];
    endcase
  end

  assign rdD = instrD[15:12];
  // Stores read [15:12], they never write it
  assign writeD = regWriteD & (regSrcD != SRC_STORE);
  // Immediate in [3:0] is not a register read
  assign useRs2D = (regSrcD == SRC_STORE) | ~aluSrcD;

  assign acceptD = instrValid & ~ctrl.stallD;
  assign issueD = acceptD & ~ctrl.flushE;

  addressDecode readDec1 (.regNum(rs1D), .mode(mode), .userBank(userBankD), .sel(rdSel1));
  addressDecode readDec2 (.regNum(rs2D), .mode(mode), .userBank(userBankD), .sel(rdSel2));

  // ====================
  // Pipeline registers
  // ====================
  // Strobes, bubble in E on flush or no accept
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteE <= 1'b0;
      loadE     <= 1'b0;
      useRs1E   <= 1'b0;
      useRs2E   <= 1'b0;
      regWriteM <= 1'b0;
      regWriteW <= 1'b0;
    end else begin
      regWriteE <= issueD & writeD;
      loadE     <= issueD & loadD;
      useRs1E   <= issueD;
      useRs2E   <= issueD & useRs2D;
      regWriteM <= regWriteE;
      regWriteW <= regWriteM;
    end
  end

  // Numbers, mode and bank flag ride along
  always_ff @(posedge clk) begin
    if (acceptD) begin
      rs1E      <= rs1D;
      rs2E      <= rs2D;
      rdE       <= rdD;
      modeE     <= mode;
      userBankE <= userBankD;
    end
    rdM       <= rdE;
    modeM     <= modeE;
    userBankM <= userBankE;
    rdW       <= rdM;
    modeW     <= modeM;
    userBankW <= userBankM;
  end

  // ====================
  // Writeback select
  // ====================
  addressDecode writeDec (.regNum(rdW), .mode(modeW), .userBank(userBankW), .sel(wrSel));
  assign wrEn = regWriteW;

  // ====================
  // Match detection
  // ====================
  // E sources vs later destinations, for forwarding
  assign match.match1EM = regWriteM & useRs1E & (rdM == rs1E);
  assign match.match1EW = regWriteW & useRs1E & (rdW == rs1E);
  assign match.match2EM = regWriteM & useRs2E & (rdM == rs2E);
  assign match.match2EW = regWriteW & useRs2E & (rdW == rs2E);
  // D sources vs E destination, for load-use
  assign match.match1DE = regWriteE & instrValid & (rdE == rs1D);
  assign match.match2DE = regWriteE & instrValid & useRs2D & (rdE == rs2D);
  assign match.loadE    = loadE;

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none
`include "regbank_defs.svh"

module regFile (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [`PHYS_REGS-1:0] rdSel1,
  input  logic [`PHYS_REGS-1:0] rdSel2,
  input  logic [`PHYS_REGS-1:0] wrSel,
  input  logic                  wrEn,
  input  logic [`DATA_W-1:0]    writeData,
  output logic [`DATA_W-1:0]    rd1,
  output logic [`DATA_W-1:0]    rd2
);

  // Physical registers, all banks flattened
  logic [`DATA_W-1:0] regs [`PHYS_REGS];

  // ====================
  // Write port
  // ====================
  // Update on edge ending the W cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `PHYS_REGS; i++) begin
        if (wrEn && wrSel[i]) begin
          regs[i] <= writeData;
        end
      end
    end
  end

  // ====================
  // Read ports
  // ====================
  // OR-mux, zero select reads zero
  always_comb begin
    rd1 = '0;
    rd2 = '0;
    for (int i = 0; i < `PHYS_REGS; i++) begin
      if (rdSel1[i]) rd1 = rd1 | regs[i];
      if (rdSel2[i]) rd2 = rd2 | regs[i];
    end
  end

endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
`default_nettype none

module hazardUnit import instrPkg::*; (
  hazardMatchIf.hazard match,
  pipeCtrlIf.hazard    ctrl
);

  logic loadUse;

  // ====================
  // Forwarding
  // ====================
  // Port 1 of the E instruction
  always_comb begin
    if (match.match1EM) begin
      // Newest result first
      ctrl.fwdA = FWD_M;
    end else if (match.match1EW) begin
      ctrl.fwdA = FWD_W;
    end else begin
      ctrl.fwdA = FWD_REG;
    end
  end

  // Port 2, immediates already masked upstream
  always_comb begin
    if (match.match2EM) begin
      ctrl.fwdB = FWD_M;
    end else if (match.match2EW) begin
      ctrl.fwdB = FWD_W;
    end else begin
      ctrl.fwdB = FWD_REG;
    end
  end

  // ====================
  // Load-use
  // ====================
  // Load data is not ready until after M,
  // so a reader right behind it waits a cycle
  assign loadUse = match.loadE & (match.match1DE | match.match2DE);

  // Hold D and bubble E together
  assign ctrl.stallD = loadUse;
  assign ctrl.flushE = loadUse;

  // Bubble clears the E write strobe,
  // so the stall cannot repeat next cycle

endmodule

`default_nettype wire

/* verilog/regAccessUnit.sv */
`default_nettype none
`include "regbank_defs.svh"

module regAccessUnit import modePkg::*, instrPkg::*; (
  input  logic               clk,
  input  logic               arstN,
  input  logic [31:0]        instrD,
  input  logic               instrValid,
  input  regSrc_e            regSrc,
  input  logic               aluSrc,
  input  logic               userBank,
  input  logic               regWrite,
  input  logic               load,
  input  cpuMode_e           mode,
  input  logic [`DATA_W-1:0] writeData,
  output logic [`DATA_W-1:0] rd1,
  output logic [`DATA_W-1:0] rd2,
  output fwdSel_e            fwdA,
  output fwdSel_e            fwdB,
  output logic               stallD
);

  // One-hot selects into the register file
  logic [`PHYS_REGS-1:0] rdSel1;
  logic [`PHYS_REGS-1:0] rdSel2;
  logic [`PHYS_REGS-1:0] wrSel;
  logic                  wrEn;

  hazardMatchIf matchBus ();
  pipeCtrlIf    ctrlBus ();

  // ====================
  // Address side
  // ====================
  addressPath uPath (
    .clk        (clk),
    .arstN      (arstN),
    .instrD     (instrD),
    .instrValid (instrValid),
    .regSrcD    (regSrc),
    .aluSrcD    (aluSrc),
    .userBankD  (userBank),
    .regWriteD  (regWrite),
    .loadD      (load),
    .mode       (mode),
    .rdSel1     (rdSel1),
    .rdSel2     (rdSel2),
    .wrSel      (wrSel),
    .wrEn       (wrEn),
    .match      (matchBus.path),
    .ctrl       (ctrlBus.path)
  );

  // Banked storage
  regFile uRegs (
    .clk       (clk),
    .arstN     (arstN),
    .rdSel1    (rdSel1),
    .rdSel2    (rdSel2),
    .wrSel     (wrSel),
    .wrEn      (wrEn),
    .writeData (writeData),
    .rd1       (rd1),
    .rd2       (rd2)
  );

  hazardUnit uHazard (
    .match (matchBus.hazard),
    .ctrl  (ctrlBus.hazard)
  );

  // Controls out to the datapath
  assign fwdA   = ctrlBus.fwdA;
  assign fwdB   = ctrlBus.fwdB;
  assign stallD = ctrlBus.stallD;

endmodule

`default_nettype wire

/* testbench/regAccessUnit_assert.sv */
`default_nettype none
`include "regbank_defs.svh"

module regAccessUnitAssert (
  input logic                  clk,
  input logic                  arstN,
  input logic [`PHYS_REGS-1:0] rdSel1,
  input logic [`PHYS_REGS-1:0] rdSel2,
  input logic [`PHYS_REGS-1:0] wrSel,
  input logic                  wrEn,
  input logic                  stallD,
  input logic                  flushE
);

  // ====================
  // Select encoding
  // ====================
  // One physical slot or none
  selOneHot: assert property (
    @(posedge clk) disable iff (!arstN)
      $onehot0(rdSel1) && $onehot0(rdSel2) && $onehot0(wrSel)
  ) else $error("physical select drives more than one register");

  // A write always hits exactly one slot
  writeOneHot: assert property (
    @(posedge clk) disable iff (!arstN) wrEn |-> $onehot(wrSel)
  ) else $error("write enabled without a single write select");

  // ====================
  // Load-use control
  // ====================
  stallOneCycle: assert property (
    @(posedge clk) disable iff (!arstN) stallD |=> !stallD
  ) else $error("decode stall held for two cycles");

  flushWithStall: assert property (
    @(posedge clk) disable iff (!arstN) stallD |-> flushE
  ) else $error("decode stall without an E bubble");

endmodule

bind addressPath regAccessUnitAssert pathChecks (
  .clk    (clk),
  .arstN  (arstN),
  .rdSel1 (rdSel1),
  .rdSel2 (rdSel2),
  .wrSel  (wrSel),
  .wrEn   (wrEn),
  .stallD (ctrl.stallD),
  .flushE (ctrl.flushE)
);

`default_nettype wire

/* testbench/tb_regAccessUnit.sv */
`default_nettype none
`include "regbank_defs.svh"

module tb_regAccessUnit import modePkg::*, instrPkg::*;;

  localparam logic [31:0] Seed = 32'h809bc794;
  localparam int StallLimit = 8;

  logic               clk;
  logic               arstN;
  logic [31:0]        instrD;
  logic               instrValid;
  regSrc_e            regSrc;
  logic               aluSrc;
  logic               userBank;
  logic               regWrite;
  logic               load;
  cpuMode_e           mode;
  logic [`DATA_W-1:0] writeData;
  logic [`DATA_W-1:0] rd1;
  logic [`DATA_W-1:0] rd2;
  fwdSel_e            fwdA;
  fwdSel_e            fwdB;
  logic               stallD;

  // Reference register file by physical slot
  logic [`DATA_W-1:0] refRegs [`PHYS_REGS];
  // Model of the E, M and W stages at index 1 to 3
  logic               pipeWrite [1:3];
  int                 pipeIdx [1:3];
  logic [`DATA_W-1:0] pipeData [1:3];

  regAccessUnit UUT (
    .clk(clk), .arstN(arstN), .instrD(instrD), .instrValid(instrValid),
    .regSrc(regSrc), .aluSrc(aluSrc), .userBank(userBank), .regWrite(regWrite),
    .load(load), .mode(mode), .writeData(writeData), .rd1(rd1), .rd2(rd2),
    .fwdA(fwdA), .fwdB(fwdB), .stallD(stallD)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================
  // Physical slot of an architectural register
  // r8-r12 banked in FIQ only, r15 at slot 30
  function automatic int physIndex(input logic [3:0] num, input cpuMode_e m, input logic ub);
    int bank;
    int n;
    n = int'(num);
    bank = 0;
    if (!ub) begin
      case (m)
        MODE_FIQ: bank = 1;
        MODE_IRQ: bank = 2;
        MODE_SVC: bank = 3;
        MODE_ABT: bank = 4;
        MODE_UND: bank = 5;
        default:  bank = 0;
      endcase
    end
    if (n == 15) return 30;
    if (n >= 13) return 18 + 2 * bank + (n - 13);
    if (n >= 8 && bank == 1) return 13 + (n - 8);
    return n;
  endfunction

  function automatic logic [31:0] buildInstr(input logic [3:0] rn, input logic [3:0] rd,
                                             input logic [3:0] rm);
    return {12'h000, rn, rd, 8'h00, rm};
  endfunction

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic drive(input regSrc_e src, input logic [3:0] rn, input logic [3:0] rd,
                       input logic [3:0] rm, input logic wr, input logic ld, input logic imm);
    instrD     = buildInstr(rn, rd, rm);
    instrValid = 1'b1;
    regSrc     = src;
    regWrite   = wr;
    load       = ld;
    aluSrc     = imm;
  endtask

  task automatic idle();
    instrValid = 1'b0;
    regWrite   = 1'b0;
    load       = 1'b0;
  endtask

  // Runs from a negedge to 2 units past the next rising edge
  task automatic advance();
    logic accepted;
    accepted = instrValid && !stallD;
    // Write lands on the edge ending W
    if (pipeWrite[3]) begin
      refRegs[pipeIdx[3]] = pipeData[3];
    end
    for (int s = 3; s > 1; s--) begin
      pipeWrite[s] = pipeWrite[s-1];
      pipeIdx[s]   = pipeIdx[s-1];
      pipeData[s]  = pipeData[s-1];
    end
    // No write for a bubble or a store
    pipeWrite[1] = accepted && regWrite && (regSrc != SRC_STORE);
    pipeIdx[1]   = physIndex(instrD[15:12], mode, userBank);
    pipeData[1]  = $urandom;
    @(posedge clk);
    #2;
    // Junk outside W must not land anywhere
    writeData = pipeWrite[3] ? pipeData[3] : $urandom;
  endtask

  task automatic tick();
    @(negedge clk);
    advance();
  endtask

  // Read one number on both ports against the model
  task automatic readBack(input logic [3:0] num, input cpuMode_e m, input logic ub,
                          output logic [`DATA_W-1:0] value);
    idle();
    regSrc   = SRC_DP;
    aluSrc   = 1'b0;
    mode     = m;
    userBank = ub;
    instrD   = buildInstr(num, 4'd0, num);
    @(negedge clk);
    checkEq("rd1 banked read", rd1, refRegs[physIndex(num, m, ub)]);
    checkEq("rd2 banked read", rd2, refRegs[physIndex(num, m, ub)]);
    value = rd1;
    advance();
  endtask

  // Runs from a negedge to the first negedge with stallD low
  task automatic waitStallEnd(output int cycles);
    cycles = 0;
    while (stallD) begin
      cycles++;
      if (cycles > StallLimit) begin
        $display("Timed out waiting for stallD to fall after %0d cycles", StallLimit);
        $display("CHECKS FAILED");
        $fatal(1, "stall never released");
      end
      advance();
      @(negedge clk);
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic resetTest();
    idle();
    instrD = buildInstr(4'd13, 4'd0, 4'd14);
    @(negedge clk);
    checkEq("rd1 after reset", rd1, 32'd0);
    checkEq("rd2 after reset", rd2, 32'd0);
    checkEq("fwdA after reset", 32'(fwdA), 32'(FWD_REG));
    checkEq("fwdB after reset", 32'(fwdB), 32'(FWD_REG));
    checkEq("stallD after reset", 32'(stallD), 32'd0);
    advance();
  endtask

  task automatic bankedR13Test();
    logic [`DATA_W-1:0] svcValue;
    logic [`DATA_W-1:0] fiqValue;
    logic [`DATA_W-1:0] usrValue;
    logic [`DATA_W-1:0] sysValue;
    userBank = 1'b0;
    // Back-to-back r13 writes in three banks
    mode = MODE_SVC;
    drive(SRC_DP, 4'd0, 4'd13, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    mode = MODE_FIQ;
    drive(SRC_DP, 4'd0, 4'd13, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    mode = MODE_USR;
    drive(SRC_DP, 4'd0, 4'd13, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    idle();
    repeat (3) tick();
    readBack(4'd13, MODE_SVC, 1'b0, svcValue);
    readBack(4'd13, MODE_FIQ, 1'b0, fiqValue);
    readBack(4'd13, MODE_USR, 1'b0, usrValue);
    readBack(4'd13, MODE_SYS, 1'b0, sysValue);
    checkEq("SVC and FIQ r13 differ", 32'(svcValue != fiqValue), 32'd1);
    checkEq("FIQ and USR r13 differ", 32'(fiqValue != usrValue), 32'd1);
    checkEq("SYS r13 shares USR", sysValue, usrValue);
  endtask

  task automatic fiqBankTest();
    logic [`DATA_W-1:0] fiqValue;
    logic [`DATA_W-1:0] irqValue;
    logic [`DATA_W-1:0] userValue;
    userBank = 1'b0;
    mode = MODE_USR;
    drive(SRC_DP, 4'd0, 4'd8, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    mode = MODE_FIQ;
    drive(SRC_DP, 4'd0, 4'd8, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    idle();
    repeat (3) tick();
    readBack(4'd8, MODE_FIQ, 1'b0, fiqValue);
    readBack(4'd8, MODE_IRQ, 1'b0, irqValue);
    checkEq("FIQ and IRQ r8 differ", 32'(fiqValue != irqValue), 32'd1);
    // User-bank strobe in FIQ sees the shared r8
    readBack(4'd8, MODE_FIQ, 1'b1, userValue);
    checkEq("userBank r8 in FIQ", userValue, irqValue);
  endtask

  task automatic forwardTest();
    logic [`DATA_W-1:0] newValue;
    mode = MODE_USR;
    userBank = 1'b0;
    // Distance 1 with the producer in M
    drive(SRC_DP, 4'd2, 4'd1, 4'd3, 1'b1, 1'b0, 1'b0);
    tick();
    drive(SRC_DP, 4'd1, 4'd4, 4'd1, 1'b1, 1'b0, 1'b0);
    tick();
    idle();
    @(negedge clk);
    checkEq("fwdA distance 1", 32'(fwdA), 32'(FWD_M));
    checkEq("fwdB distance 1", 32'(fwdB), 32'(FWD_M));
    advance();
    // Distance 2 with an unrelated writer in between
    drive(SRC_DP, 4'd2, 4'd5, 4'd3, 1'b1, 1'b0, 1'b0);
    tick();
    drive(SRC_DP, 4'd7, 4'd6, 4'd7, 1'b1, 1'b0, 1'b0);
    tick();
    drive(SRC_DP, 4'd5, 4'd10, 4'd5, 1'b1, 1'b0, 1'b0);
    tick();
    idle();
    @(negedge clk);
    checkEq("fwdA distance 2", 32'(fwdA), 32'(FWD_W));
    checkEq("fwdB distance 2", 32'(fwdB), 32'(FWD_W));
    advance();
    // Distance 3 reads the register file
    drive(SRC_DP, 4'd0, 4'd9, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    newValue = pipeData[1];
    idle();
    repeat (2) tick();
    drive(SRC_DP, 4'd9, 4'd11, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    idle();
    instrD = buildInstr(4'd9, 4'd0, 4'd0);
    @(negedge clk);
    checkEq("fwdA distance 3", 32'(fwdA), 32'(FWD_REG));
    checkEq("r9 after writeback", rd1, newValue);
    advance();
    // PCREL reads r15, so r3 in M is no match
    drive(SRC_DP, 4'd0, 4'd3, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    drive(SRC_PCREL, 4'd3, 4'd12, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    idle();
    @(negedge clk);
    checkEq("fwdA PCREL no r15 writer", 32'(fwdA), 32'(FWD_REG));
    advance();
    drive(SRC_DP, 4'd0, 4'd15, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    drive(SRC_PCREL, 4'd3, 4'd12, 4'd0, 1'b1, 1'b0, 1'b1);
    tick();
    idle();
    @(negedge clk);
    checkEq("fwdA PCREL after r15 write", 32'(fwdA), 32'(FWD_M));
    advance();
    repeat (3) tick();
  endtask

  task automatic loadUseTest();
    int stallCycles;
    mode = MODE_USR;
    userBank = 1'b0;
    // Load r6 followed by a port 1 reader of r6
    drive(SRC_DP, 4'd0, 4'd6, 4'd0, 1'b1, 1'b1, 1'b1);
    tick();
    drive(SRC_DP, 4'd6, 4'd7, 4'd0, 1'b1, 1'b0, 1'b1);
    @(negedge clk);
    checkEq("stallD on load-use", 32'(stallD), 32'd1);
    waitStallEnd(stallCycles);
    checkEq("stall length", 32'(stallCycles), 32'd1);
    advance();
    idle();
    @(negedge clk);
    // After the bubble the load sits in W
    checkEq("fwdA after load-use", 32'(fwdA), 32'(FWD_W));
    advance();
    // Immediate in [3:0] means no port 2 read
    drive(SRC_DP, 4'd0, 4'd8, 4'd0, 1'b1, 1'b1, 1'b1);
    tick();
    drive(SRC_DP, 4'd0, 4'd9, 4'd8, 1'b1, 1'b0, 1'b1);
    @(negedge clk);
    checkEq("no stall with aluSrc", 32'(stallD), 32'd0);
    advance();
    idle();
    @(negedge clk);
    checkEq("fwdB with aluSrc", 32'(fwdB), 32'(FWD_REG));
    advance();
    // Same pair with a register operand stalls
    drive(SRC_DP, 4'd0, 4'd8, 4'd0, 1'b1, 1'b1, 1'b1);
    tick();
    drive(SRC_DP, 4'd0, 4'd9, 4'd8, 1'b1, 1'b0, 1'b0);
    @(negedge clk);
    checkEq("stallD on port 2", 32'(stallD), 32'd1);
    waitStallEnd(stallCycles);
    checkEq("port 2 stall length", 32'(stallCycles), 32'd1);
    advance();
    idle();
    repeat (3) tick();
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    void'($urandom(Seed));
    arstN      = 1'b0;
    instrD     = '0;
    instrValid = 1'b0;
    regSrc     = SRC_DP;
    aluSrc     = 1'b0;
    userBank   = 1'b0;
    regWrite   = 1'b0;
    load       = 1'b0;
    mode       = MODE_USR;
    writeData  = '0;
    for (int i = 0; i < `PHYS_REGS; i++) begin
      refRegs[i] = '0;
    end
    for (int s = 1; s <= 3; s++) begin
      pipeWrite[s] = 1'b0;
      pipeIdx[s]   = 0;
      pipeData[s]  = '0;
    end
    repeat (3) @(posedge clk);
    #2;
    arstN = 1'b1;
    resetTest();
    bankedR13Test();
    fiqBankTest();
    forwardTest();
    loadUseTest();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* regAccessUnit.f */
+incdir+verilog
verilog/modePkg.sv
verilog/instrPkg.sv
verilog/pipeIfs.sv
verilog/addressDecode.sv
verilog/addressPath.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/regAccessUnit.sv
testbench/regAccessUnit_assert.sv
testbench/tb_regAccessUnit.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       ?= tb_regAccessUnit
FILELIST  ?= regAccessUnit.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
